// File: dv/lc4_mini_prog.svh
`ifndef LC4_MINI_PROG_SVH
`define LC4_MINI_PROG_SVH

typedef struct packed {
    logic [`LC4_XLEN-1:0]   insn;
    logic [8*12-1:0]        name;
    logic                   we;
    logic [`LC4_RSEL_W-1:0] rd;
    logic [`LC4_XLEN-1:0]   data;
    logic [2:0]             nzp;
} prog_entry_t;

localparam int NUM_VECS = 22;

// columns: instruction word, test name, expected write enable, rd, data, nzp
// registers start at zero, entry k sits at pc 16'h8200 + k
localparam prog_entry_t PROG [NUM_VECS] = '{
    '{16'h9205, "const_pos",    1'b1, 3'd1, 16'h0005, 3'b001},
    '{16'h95FD, "const_neg",    1'b1, 3'd2, 16'hFFFD, 3'b100},
    // r2 by bypass, r1 by write-through
    '{16'h1642, "add_dist12",   1'b1, 3'd3, 16'h0002, 3'b001},
    // r3 by bypass, r1 from the register file
    '{16'h18D1, "sub_dist13",   1'b1, 3'd4, 16'hFFFD, 3'b100},
    '{16'h5A81, "and_rr",       1'b1, 3'd5, 16'h0005, 3'b001},
    '{16'h5D13, "or_rr",        1'b1, 3'd6, 16'hFFFF, 3'b100},
    '{16'h5F9A, "xor_rr",       1'b1, 3'd7, 16'h0002, 3'b001},
    '{16'h5188, "not_zero",     1'b1, 3'd0, 16'h0000, 3'b010},
    '{16'h92FF, "const_max",    1'b1, 3'd1, 16'h00FF, 3'b001},
    // ffff + 00ff carries out of bit 15
    '{16'h1981, "add_wrap",     1'b1, 3'd4, 16'h00FE, 3'b001},
    '{16'h1B2F, "addi_pos",     1'b1, 3'd5, 16'h010D, 3'b001},
    '{16'h1D70, "addi_neg",     1'b1, 3'd6, 16'h00FD, 3'b001},
    '{16'h5EBC, "andi_neg",     1'b1, 3'd7, 16'hFFFC, 3'b100},
    '{16'h5167, "andi_pos",     1'b1, 3'd0, 16'h0005, 3'b001},
    '{16'h128A, "mul_noop",     1'b0, 3'd0, 16'h0000, 3'b000},
    // r1 must still hold 00ff after the mul
    '{16'h1640, "add_aftmul",   1'b1, 3'd3, 16'h0104, 3'b001},
    '{16'h0000, "zero_word",    1'b0, 3'd0, 16'h0000, 3'b000},
    // r0 must still hold 0005 after the zero word
    '{16'h1811, "sub_aftnop",   1'b1, 3'd4, 16'hFF06, 3'b100},
    '{16'h9A00, "const_zero",   1'b1, 3'd5, 16'h0000, 3'b010},
    '{16'h5D1C, "xor_self",     1'b1, 3'd6, 16'h0000, 3'b010},
    '{16'h5F48, "not_ones",     1'b1, 3'd7, 16'hFFFF, 3'b100},
    '{16'h53C4, "and_bypass",   1'b1, 3'd1, 16'hFF06, 3'b100}
};

`endif

// File: dv/lc4_mini_tb.sv
`timescale 1ns/100ps
`include "lc4_mini_config.svh"

module lc4_mini_tb;
    import lc4_mini_pkg::*;

    `include "lc4_mini_prog.svh"

    localparam int RESET_CYCLES   = 4;
    localparam int TIMEOUT_CYCLES = NUM_VECS + `LC4_PIPE_DEPTH + RESET_CYCLES + 10;

    logic                 gwe;
    logic                 i_arst_n;
    lc4_insn_u            i_insn;
    logic [`LC4_XLEN-1:0] o_pc;
    lc4_wb_t              o_wb;

    int cycle_count = 0;
    int err_count   = 0;
    int test_errs   = 0;
    int pass_count  = 0;
    int fail_count  = 0;
    int wait_edges  = 0;

    lc4_mini_core dut0 (
        .gwe      (gwe),
        .i_arst_n (i_arst_n),
        .o_pc     (o_pc),
        .i_insn   (i_insn),
        .o_wb     (o_wb)
    );

    initial begin
        gwe = 1'b0;
        forever #2 gwe = ~gwe;
    end

    // instruction memory, zero past the end of the program
    function automatic logic [`LC4_XLEN-1:0] fetch_word(input logic [`LC4_XLEN-1:0] addr);
        logic [`LC4_XLEN-1:0] idx;
        idx = addr - `LC4_RESET_PC;
        if (idx < NUM_VECS) begin
            return PROG[idx].insn;
        end
        return '0;
    endfunction

    // present the word for the pc that holds after this edge
    always @(posedge gwe) begin
        if (i_arst_n) begin
            i_insn <= fetch_word(o_pc + 1'b1);
        end else begin
            i_insn <= fetch_word(`LC4_RESET_PC);
        end
    end

    always @(posedge gwe) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: writeback never finished after %0d cycles", cycle_count);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    task automatic check_field(input string what, input int idx,
                               input logic [`LC4_XLEN-1:0] got,
                               input logic [`LC4_XLEN-1:0] exp);
        assert (got === exp) else begin
            $display("mismatch at %0d ns: test %0d %s is %h, expected %h",
                     $time, idx, what, got, exp);
            test_errs++;
            err_count++;
        end
    endtask

    initial begin
        i_arst_n = 1'b0;
        i_insn   = fetch_word(`LC4_RESET_PC);
        repeat (RESET_CYCLES) @(posedge gwe);
        i_arst_n <= 1'b1;

        @(negedge gwe);
        check_field("valid after reset", -1, o_wb.valid, 1'b0);
        check_field("pc after reset", -1, o_pc, `LC4_RESET_PC);

        // first retirement comes a fixed depth after reset release
        while (o_wb.valid !== 1'b1) begin
            @(negedge gwe);
            wait_edges++;
        end
        check_field("edges to first retire", -1, wait_edges, `LC4_PIPE_DEPTH);

        for (int i = 0; i < NUM_VECS; i++) begin
            if (i > 0) begin
                @(negedge gwe);
            end
            test_errs = 0;
            check_field("valid", i, o_wb.valid, 1'b1);
            check_field("pc", i, o_wb.pc, `LC4_RESET_PC + i);
            // fetch runs a full pipe depth ahead of the retiring pc
            check_field("fetch pc", i, o_pc, `LC4_RESET_PC + i + `LC4_PIPE_DEPTH);
            check_field("insn", i, o_wb.insn, PROG[i].insn);
            check_field("rf_we", i, o_wb.rf_we, PROG[i].we);
            if (PROG[i].we) begin
                check_field("wsel", i, o_wb.wsel, PROG[i].rd);
                check_field("wdata", i, o_wb.wdata, PROG[i].data);
                check_field("nzp", i, o_wb.nzp, PROG[i].nzp);
            end
            if (test_errs == 0) begin
                pass_count++;
                $display("test %0d %0s: ok", i, PROG[i].name);
            end else begin
                fail_count++;
                $display("test %0d %0s: %0d error(s)", i, PROG[i].name, test_errs);
            end
        end

        $display("tests %0d, passed %0d, failed %0d, errors %0d",
                 NUM_VECS, pass_count, fail_count, err_count);
        if (err_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// File: hw/lc4_exec_writeback.sv
`timescale 1ns/100ps
`include "lc4_mini_config.svh"

module lc4_exec_writeback (
    input  logic                      gwe,
    input  logic                      i_arst_n,
    input  lc4_mini_pkg::lc4_opnd_t   i_opnd,
    output lc4_mini_pkg::lc4_wb_t     o_wb
);
    import lc4_mini_pkg::*;

    logic                   rs_byp;
    logic                   rt_byp;
    logic [`LC4_XLEN-1:0]   op_a;
    logic [`LC4_XLEN-1:0]   op_b;
    logic [`LC4_XLEN-1:0]   alu_res;
    logic [2:0]             nzp;
    logic                   valid_q;
    logic                   we_q;
    logic [`LC4_XLEN-1:0]   pc_q;
    logic [`LC4_XLEN-1:0]   insn_q;
    logic [`LC4_RSEL_W-1:0] wsel_q;
    logic [`LC4_XLEN-1:0]   wdata_q;
    logic [2:0]             nzp_q;

    // bypass from the instruction retiring this cycle
    assign rs_byp = o_wb.valid && o_wb.rf_we && i_opnd.dec.rs_re &&
                    (o_wb.wsel == i_opnd.dec.rs_sel);
    assign rt_byp = o_wb.valid && o_wb.rf_we && i_opnd.dec.rt_re &&
                    (o_wb.wsel == i_opnd.dec.rt_sel);

    assign op_a = rs_byp ? o_wb.wdata : i_opnd.rs_data;
    assign op_b = i_opnd.dec.use_imm ? i_opnd.dec.imm :
                  rt_byp ? o_wb.wdata : i_opnd.rt_data;

    always_comb begin
        case (i_opnd.dec.alu_op)
            ALU_ADD:      alu_res = op_a + op_b;
            ALU_SUB:      alu_res = op_a - op_b;
            ALU_AND:      alu_res = op_a & op_b;
            ALU_OR:       alu_res = op_a | op_b;
            ALU_XOR:      alu_res = op_a ^ op_b;
            ALU_NOT:      alu_res = ~op_a;
            ALU_PASS_IMM: alu_res = i_opnd.dec.imm;
            default:      alu_res = '0;
        endcase
    end

    // n, z, p from the two's complement result
    always_comb begin
        if ($signed(alu_res) < 0) begin
            nzp = 3'b100;
        end else if (alu_res == '0) begin
            nzp = 3'b010;
        end else begin
            nzp = 3'b001;
        end
    end

    always_ff @(posedge gwe or negedge i_arst_n) begin
        if (!i_arst_n) begin
            valid_q <= 1'b0;
            we_q    <= 1'b0;
        end else begin
            valid_q <= i_opnd.dec.valid;
            we_q    <= i_opnd.dec.valid & i_opnd.dec.rf_we;
        end
    end

    always_ff @(posedge gwe) begin
        pc_q    <= i_opnd.dec.pc;
        insn_q  <= i_opnd.dec.insn;
        wsel_q  <= i_opnd.dec.rd_sel;
        wdata_q <= alu_res;
        nzp_q   <= nzp;
    end

    always_comb begin
        o_wb.valid = valid_q;
        o_wb.pc    = pc_q;
        o_wb.insn  = insn_q;
        o_wb.rf_we = we_q;
        o_wb.wsel  = wsel_q;
        o_wb.wdata = wdata_q;
        o_wb.nzp   = nzp_q;
    end

endmodule

// File: hw/lc4_fetch_decode.sv
`timescale 1ns/100ps
`include "lc4_mini_config.svh"

module lc4_fetch_decode (
    input  logic                      gwe,
    input  logic                      i_arst_n,
    input  lc4_mini_pkg::lc4_insn_u   i_insn,
    output logic [`LC4_XLEN-1:0]      o_pc,
    output lc4_mini_pkg::lc4_dec_t    o_dec
);
    import lc4_mini_pkg::*;

    logic                 dec_valid_q;
    logic [`LC4_XLEN-1:0] dec_pc_q;
    lc4_insn_u            dec_insn_q;
    logic                 dec_we;

    // no redirects, so fetch just walks forward
    always_ff @(posedge gwe or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_pc        <= `LC4_RESET_PC;
            dec_valid_q <= 1'b0;
        end else begin
            o_pc        <= o_pc + 1'b1;
            dec_valid_q <= 1'b1;
        end
    end

    always_ff @(posedge gwe) begin
        dec_pc_q   <= o_pc;
        dec_insn_q <= i_insn;
    end

    always_comb begin
        o_dec        = '0;
        dec_we       = 1'b0;
        o_dec.valid  = dec_valid_q;
        o_dec.pc     = dec_pc_q;
        o_dec.insn   = dec_insn_q;
        o_dec.alu_op = ALU_ADD;
        o_dec.rs_sel = dec_insn_q.rr.rs;
        o_dec.rt_sel = dec_insn_q.rr.rt;
        o_dec.rd_sel = dec_insn_q.rr.rd;
        o_dec.imm    = {{(`LC4_XLEN-5){dec_insn_q.ri.imm5[4]}}, dec_insn_q.ri.imm5};

        case (dec_insn_q.rr.opcode)
            OP_ARITH: begin
                if (dec_insn_q.ri.imm_flag) begin
                    o_dec.rs_re   = 1'b1;
                    o_dec.use_imm = 1'b1;
                    dec_we        = 1'b1;
                end else if (dec_insn_q.rr.sub_op == 3'b000 || dec_insn_q.rr.sub_op == 3'b010) begin
                    // MUL and DIV stay no-ops
                    o_dec.alu_op = (dec_insn_q.rr.sub_op == 3'b000) ? ALU_ADD : ALU_SUB;
                    o_dec.rs_re  = 1'b1;
                    o_dec.rt_re  = 1'b1;
                    dec_we       = 1'b1;
                end
            end
            OP_LOGIC: begin
                o_dec.rs_re = 1'b1;
                dec_we      = 1'b1;
                if (dec_insn_q.ri.imm_flag) begin
                    o_dec.alu_op  = ALU_AND;
                    o_dec.use_imm = 1'b1;
                end else begin
                    case (dec_insn_q.rr.sub_op[1:0])
                        2'b00: o_dec.alu_op = ALU_AND;
                        2'b01: o_dec.alu_op = ALU_NOT;
                        2'b10: o_dec.alu_op = ALU_OR;
                        default: o_dec.alu_op = ALU_XOR;
                    endcase
                    // NOT has no second source
                    o_dec.rt_re = (dec_insn_q.rr.sub_op[1:0] != 2'b01);
                end
            end
            OP_CONST: begin
                o_dec.alu_op  = ALU_PASS_IMM;
                o_dec.use_imm = 1'b1;
                o_dec.imm     = {{(`LC4_XLEN-9){dec_insn_q.c.imm9[8]}}, dec_insn_q.c.imm9};
                dec_we        = 1'b1;
            end
            default: begin
                dec_we = 1'b0;
            end
        endcase

        o_dec.rf_we = dec_valid_q & dec_we;
    end

endmodule

// File: hw/lc4_mini_core.sv
`timescale 1ns/100ps
`include "lc4_mini_config.svh"

module lc4_mini_core (
    input  logic                      gwe,
    input  logic                      i_arst_n,
    output logic [`LC4_XLEN-1:0]      o_pc,
    input  lc4_mini_pkg::lc4_insn_u   i_insn,
    output lc4_mini_pkg::lc4_wb_t     o_wb
);
    import lc4_mini_pkg::*;

    lc4_dec_t  dec;
    lc4_opnd_t opnd;

    // fetch and decode, one edge into the decode register
    lc4_fetch_decode u_fetch_decode (
        .gwe      (gwe),
        .i_arst_n (i_arst_n),
        .i_insn   (i_insn),
        .o_pc     (o_pc),
        .o_dec    (dec)
    );

    // register file read, written back from the retiring instruction
    lc4_operand_buffer u_operand_buffer (
        .gwe      (gwe),
        .i_arst_n (i_arst_n),
        .i_dec    (dec),
        .i_wb     (o_wb),
        .o_opnd   (opnd)
    );

    // execute and writeback, also the trace seen at the top
    lc4_exec_writeback u_exec_writeback (
        .gwe      (gwe),
        .i_arst_n (i_arst_n),
        .i_opnd   (opnd),
        .o_wb     (o_wb)
    );

endmodule

// File: hw/lc4_mini_pkg.sv
`include "lc4_mini_config.svh"

package lc4_mini_pkg;

    // opcode groups the core executes, anything else retires as a no-op
    typedef enum logic [3:0] {
        OP_ARITH = 4'b0001,
        OP_LOGIC = 4'b0101,
        OP_CONST = 4'b1001
    } lc4_opcode_e;

    // register form: rd <- rs op rt
    typedef struct packed {
        lc4_opcode_e            opcode;
        logic [`LC4_RSEL_W-1:0] rd;
        logic [`LC4_RSEL_W-1:0] rs;
        logic [2:0]             sub_op;
        logic [`LC4_RSEL_W-1:0] rt;
    } lc4_insn_rr_t;

    // immediate form, imm_flag overlays sub_op[2]
    typedef struct packed {
        lc4_opcode_e            opcode;
        logic [`LC4_RSEL_W-1:0] rd;
        logic [`LC4_RSEL_W-1:0] rs;
        logic                   imm_flag;
        logic [4:0]             imm5;
    } lc4_insn_ri_t;

    typedef struct packed {
        lc4_opcode_e            opcode;
        logic [`LC4_RSEL_W-1:0] rd;
        logic [8:0]             imm9;
    } lc4_insn_c_t;

    typedef union packed {
        lc4_insn_rr_t rr;
        lc4_insn_ri_t ri;
        lc4_insn_c_t  c;
    } lc4_insn_u;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOT,
        ALU_PASS_IMM
    } lc4_alu_op_e;

    typedef struct packed {
        logic                   valid;
        logic [`LC4_XLEN-1:0]   pc;
        lc4_insn_u              insn;
        lc4_alu_op_e            alu_op;
        logic [`LC4_RSEL_W-1:0] rs_sel;
        logic [`LC4_RSEL_W-1:0] rt_sel;
        logic [`LC4_RSEL_W-1:0] rd_sel;
        logic                   rs_re;
        logic                   rt_re;
        logic                   rf_we;
        logic                   use_imm;
        logic [`LC4_XLEN-1:0]   imm;
    } lc4_dec_t;

    typedef struct packed {
        lc4_dec_t             dec;
        logic [`LC4_XLEN-1:0] rs_data;
        logic [`LC4_XLEN-1:0] rt_data;
    } lc4_opnd_t;

    typedef struct packed {
        logic                   valid;
        logic [`LC4_XLEN-1:0]   pc;
        logic [`LC4_XLEN-1:0]   insn;
        logic                   rf_we;
        logic [`LC4_RSEL_W-1:0] wsel;
        logic [`LC4_XLEN-1:0]   wdata;
        logic [2:0]             nzp;
    } lc4_wb_t;

endpackage

// File: hw/lc4_operand_buffer.sv
`timescale 1ns/100ps
`include "lc4_mini_config.svh"

module lc4_operand_buffer (
    input  logic                      gwe,
    input  logic                      i_arst_n,
    input  lc4_mini_pkg::lc4_dec_t    i_dec,
    input  lc4_mini_pkg::lc4_wb_t     i_wb,
    output lc4_mini_pkg::lc4_opnd_t   o_opnd
);
    import lc4_mini_pkg::*;

    logic [`LC4_XLEN-1:0] rf [`LC4_NREGS];
    logic                 wb_fire;
    logic [`LC4_XLEN-1:0] rs_data;
    logic [`LC4_XLEN-1:0] rt_data;
    logic                 valid_q;
    lc4_dec_t             dec_q;
    logic [`LC4_XLEN-1:0] rs_q;
    logic [`LC4_XLEN-1:0] rt_q;

    assign wb_fire = i_wb.valid & i_wb.rf_we;

    // register file, one write port fed from writeback
    always_ff @(posedge gwe or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int i = 0; i < `LC4_NREGS; i++) begin
                rf[i] <= '0;
            end
        end else if (wb_fire) begin
            rf[i_wb.wsel] <= i_wb.wdata;
        end
    end

    // write-through covers the instruction two behind the writer
    assign rs_data = (wb_fire && i_wb.wsel == i_dec.rs_sel) ? i_wb.wdata : rf[i_dec.rs_sel];
    assign rt_data = (wb_fire && i_wb.wsel == i_dec.rt_sel) ? i_wb.wdata : rf[i_dec.rt_sel];

    always_ff @(posedge gwe or negedge i_arst_n) begin
        if (!i_arst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= i_dec.valid;
        end
    end

    always_ff @(posedge gwe) begin
        dec_q <= i_dec;
        rs_q  <= rs_data;
        rt_q  <= rt_data;
    end

    always_comb begin
        o_opnd.dec       = dec_q;
        o_opnd.dec.valid = valid_q;
        // a bubble never writes, whatever the stale payload says
        o_opnd.dec.rf_we = valid_q & dec_q.rf_we;
        o_opnd.rs_data   = rs_q;
        o_opnd.rt_data   = rt_q;
    end

endmodule

// File: include/lc4_mini_config.svh
`ifndef LC4_MINI_CONFIG_SVH
`define LC4_MINI_CONFIG_SVH

// datapath and address width
`define LC4_XLEN 16

// register file geometry
`define LC4_NREGS 8
`define LC4_RSEL_W 3

// first fetch address after reset
`define LC4_RESET_PC 16'h8200

// clock edges from fetch to the writeback trace
`define LC4_PIPE_DEPTH 3

`endif

// File: lc4_mini.f
+incdir+include
+incdir+dv
hw/lc4_mini_pkg.sv
hw/lc4_fetch_decode.sv
hw/lc4_operand_buffer.sv
hw/lc4_exec_writeback.sv
hw/lc4_mini_core.sv
dv/lc4_mini_tb.sv
